// File: hw/execLanesPkg.sv
// Shared types for execLanes; lane count is fixed here, opcode encodings outside ucmdE are illegal
package execLanesPkg;

	localparam int laneCount = 3;         // Lanes per bundle
	localparam int regCount  = 64;        // Register file depth

	typedef logic [5:0]  regIdT;          // Register number
	typedef logic [63:0] regValT;         // Register value

	localparam regIdT zeroRegId = 6'h3F;  // Writes here are discarded

	// Micro-op codes seen at EX3
	typedef enum logic [5:0] {
		ucmdNop   = 6'h00,                // No write
		ucmdMovRm = 6'h01,                // Store, nothing to retire
		ucmdMovMr = 6'h02,                // Load, retires memData to rmId
		ucmdMovIr = 6'h06,                // Immediate move, EX1 result
		ucmdAlu3  = 6'h0A                 // Three-operand ALU, EX1 result
	} ucmdE;

	// One lane's slot of a bundle
	typedef struct packed {
		ucmdE   op;                       // Micro-op
		regIdT  rn1Id;                    // EX1 destination
		regValT rn1Val;                   // EX1 result
		regIdT  rmId;                     // Load destination
		regValT memData;                  // Load data
		logic   flush;                    // Slot squashed by a branch
	} laneSlotS;

endpackage

// File: hw/laneIf.sv
// One lane's valid/ready stream; slot is used issue-to-lane, resId/resVal lane-to-collector
`timescale 1ns/1ps

interface laneIf import execLanesPkg::*; ();

	logic     valid;                      // Producer has data
	logic     ready;                      // Consumer can take it
	laneSlotS slot;                       // Micro-op slot
	regIdT    resId;                      // Retire destination
	regValT   resVal;                     // Retire value

	// Bundle register side
	modport issue (
		output valid,
		output slot,
		input  ready
	);

	// Lane input, mirror of issue
	modport laneIn (
		input  valid,
		input  slot,
		output ready
	);

	// Lane result side
	modport result (
		output valid,
		output resId,
		output resVal,
		input  ready
	);

	// Writeback collector side
	modport collect (
		input  valid,
		input  resId,
		input  resVal,
		output ready
	);

endinterface

// File: hw/bundleIssue.sv
// Bundle register for execLanes; refills on the edge it empties, lanes may take slots on different cycles
`timescale 1ns/1ps

module bundleIssue import execLanesPkg::*; (
	input  logic     clock,
	input  logic     arstN,
	input  logic     bundleValid,
	input  laneSlotS bundleSlot [laneCount],
	output logic     bundleReady,
	laneIf.issue     lanes [laneCount]
);

	logic                 full;           // Bundle register holds a bundle
	laneSlotS             slotReg [laneCount]; // Held slots
	logic [laneCount-1:0] taken;          // Slot already handed to its lane
	logic [laneCount-1:0] laneXfer;       // Slot transferring this cycle
	logic                 allDone;        // Every slot gone by end of cycle

	genvar gi;
	generate
		for (gi = 0; gi < laneCount; gi++) begin : gLane
			assign lanes[gi].valid = full & ~taken[gi];   // Offer until taken
			assign lanes[gi].slot  = slotReg[gi];
			assign laneXfer[gi]    = lanes[gi].valid & lanes[gi].ready;

			// Offered slot stays up and unchanged until its lane takes it
			aValidHold: assert property (
				@(posedge clock) disable iff (!arstN)
				lanes[gi].valid && !lanes[gi].ready |=>
					lanes[gi].valid && $stable(lanes[gi].slot)
			) else $error("bundleIssue: lane %0d dropped an untaken slot", gi);
		end
	endgenerate

	assign allDone     = &(taken | laneXfer);
	assign bundleReady = ~full | allDone; // Empty, or emptying this edge

	// Control state
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			full  <= 1'b0;
			taken <= '0;
		end else if (bundleReady) begin
			full  <= bundleValid;         // Refill or go empty
			taken <= '0;
		end else begin
			taken <= taken | laneXfer;    // Lanes drift, remember who is done
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (bundleReady && bundleValid) begin
			for (int i = 0; i < laneCount; i++) begin
				slotReg[i] <= bundleSlot[i];
			end
		end
	end

endmodule

// File: hw/ex3Lane.sv
// EX3 lane for execLanes; handles only ALU, immediate move, load, store and nop, a flushed slot never flags illegal
`timescale 1ns/1ps

module ex3Lane import execLanesPkg::*; (
	input  logic  clock,
	input  logic  arstN,
	laneIf.laneIn opIn,
	laneIf.result resOut,
	output logic  illegalOp
);

	regIdT  nextId;                       // Chosen destination
	regValT nextVal;                      // Chosen value
	logic   opLegal;                      // Opcode decoded
	logic   accept;                       // Slot enters output register

	logic   resValidQ;                    // Output register occupied
	regIdT  resIdQ;
	regValT resValQ;

	// Destination and value selection
	always_comb begin
		nextId  = opIn.slot.rn1Id;        // EX1 result by default
		nextVal = opIn.slot.rn1Val;
		opLegal = 1'b1;

		case (opIn.slot.op)
			ucmdNop, ucmdMovRm: begin
				nextId = zeroRegId;       // Nothing to retire
			end
			ucmdAlu3, ucmdMovIr: begin
			end
			ucmdMovMr: begin
				nextId  = opIn.slot.rmId; // Load data replaces EX1 result
				nextVal = opIn.slot.memData;
			end
			default: begin
				opLegal = opIn.slot.flush; // Squashed slot counts as nop
				nextId  = zeroRegId;
			end
		endcase

		if (opIn.slot.flush) begin
			nextId = zeroRegId;           // Branch squash discards write
		end
	end

	assign opIn.ready = ~resValidQ | resOut.ready; // Empty or draining
	assign accept     = opIn.valid & opIn.ready;

	assign resOut.valid  = resValidQ;
	assign resOut.resId  = resIdQ;
	assign resOut.resVal = resValQ;

	// Control state
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			resValidQ <= 1'b0;
			illegalOp <= 1'b0;
		end else begin
			if (accept) begin
				resValidQ <= 1'b1;
			end else if (resOut.ready) begin
				resValidQ <= 1'b0;        // Drained, nothing behind it
			end
			if (accept && !opLegal) begin
				illegalOp <= 1'b1;        // Sticky until reset
			end
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (accept) begin
			resIdQ  <= nextId;
			resValQ <= nextVal;
		end
	end

	// Flushed slot must retire to the zero register one edge later
	aFlushToZero: assert property (
		@(posedge clock) disable iff (!arstN)
		accept && opIn.slot.flush |=> resOut.valid && resOut.resId == zeroRegId
	) else $error("ex3Lane: flushed slot retired to register %0d", resOut.resId);

endmodule

// File: hw/wbCollect.sv
// Writeback collector for execLanes; same-edge conflicts go to the highest lane, register 63 reads as zero
`timescale 1ns/1ps

module wbCollect import execLanesPkg::*; (
	input  logic   clock,
	input  logic   arstN,
	laneIf.collect lanes [laneCount],
	input  logic   wbStall,
	input  regIdT  rdId,
	output regValT rdVal
);

	regValT               regFile [regCount]; // Architectural registers
	logic [laneCount-1:0] wrEn;           // Lane writes this edge
	regIdT                wrId  [laneCount];
	regValT               wrVal [laneCount];

	genvar gi;
	generate
		for (gi = 0; gi < laneCount; gi++) begin : gLane
			assign lanes[gi].ready = ~wbStall; // Stall holds every lane
			assign wrEn[gi]  = lanes[gi].valid & ~wbStall
				& (lanes[gi].resId != zeroRegId); // Zero register writes dropped
			assign wrId[gi]  = lanes[gi].resId;
			assign wrVal[gi] = lanes[gi].resVal;
		end
	endgenerate

	// Later lanes overwrite earlier ones in the same cycle
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int r = 0; r < regCount; r++) begin
				regFile[r] <= '0;
			end
		end else begin
			for (int l = 0; l < laneCount; l++) begin
				if (wrEn[l]) begin
					regFile[wrId[l]] <= wrVal[l];
				end
			end
		end
	end

	// Combinational read port
	assign rdVal = (rdId == zeroRegId) ? '0 : regFile[rdId];

	// Zero register keeps its reset value for the whole run
	aZeroRegClean: assert property (
		@(posedge clock) disable iff (!arstN)
		regFile[zeroRegId] == '0
	) else $error("wbCollect: zero register was written");

endmodule

// File: hw/execLanes.sv
// Top of execLanes; results land in the register file two edges after bundle accept, wbStall back-pressures all lanes
`timescale 1ns/1ps

module execLanes import execLanesPkg::*; (
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 bundleValid,
	input  laneSlotS             bundleSlot [laneCount],
	output logic                 bundleReady,
	input  logic                 wbStall,
	input  regIdT                rdId,
	output regValT               rdVal,
	output logic                 idle,
	output logic [laneCount-1:0] illegalOp
);

	laneIf issueBus [laneCount] ();       // Bundle register to lanes
	laneIf resBus   [laneCount] ();       // Lanes to collector

	logic [laneCount-1:0] issueValid;     // Slots still on offer
	logic [laneCount-1:0] resValid;       // Results waiting to retire

	bundleIssue issue_i (
		.clock       (clock),
		.arstN       (arstN),
		.bundleValid (bundleValid),
		.bundleSlot  (bundleSlot),
		.bundleReady (bundleReady),
		.lanes       (issueBus)
	);

	genvar gi;
	generate
		for (gi = 0; gi < laneCount; gi++) begin : gLane
			ex3Lane lane_i (
				.clock     (clock),
				.arstN     (arstN),
				.opIn      (issueBus[gi]),
				.resOut    (resBus[gi]),
				.illegalOp (illegalOp[gi])
			);
			assign issueValid[gi] = issueBus[gi].valid;
			assign resValid[gi]   = resBus[gi].valid;
		end
	endgenerate

	wbCollect collect_i (
		.clock   (clock),
		.arstN   (arstN),
		.lanes   (resBus),
		.wbStall (wbStall),
		.rdId    (rdId),
		.rdVal   (rdVal)
	);

	assign idle = ~(|issueValid | |resValid); // Nothing in flight

endmodule

// File: verif/execLanesTb.sv
// Random testbench for execLanes; model assumes lanes retire bundles in order, stops at first mismatch
`timescale 1ns/1ps

module execLanesTb import execLanesPkg::*; ();

	typedef enum {modeAlu, modeLoad, modeQuiet, modeConflict, modeMixed, modeIllegal} modeE;

	localparam int waitLimit = 200;           // Cycles before a wait gives up

	logic                 clock;
	logic                 arstN;
	logic                 bundleValid;
	laneSlotS             bundleSlot [laneCount];
	logic                 bundleReady;
	logic                 wbStall;
	regIdT                rdId;
	regValT               rdVal;
	logic                 idle;
	logic [laneCount-1:0] illegalOp;

	integer               seed;
	int                   errorCount;
	int unsigned          stallOdds;          // Stall when rnd % stallOdds == 0
	regIdT                conflictId;         // Shared target in conflict bundles
	laneSlotS             nextSlot [laneCount];
	regValT               model [regCount];   // Shadow register file
	logic [laneCount-1:0] expIllegal;

	execLanes execLanes_i (
		.clock       (clock),
		.arstN       (arstN),
		.bundleValid (bundleValid),
		.bundleSlot  (bundleSlot),
		.bundleReady (bundleReady),
		.wbStall     (wbStall),
		.rdId        (rdId),
		.rdVal       (rdVal),
		.idle        (idle),
		.illegalOp   (illegalOp)
	);

	always #4 clock = ~clock;

	function automatic int unsigned rnd();
		rnd = $random(seed);
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic compareValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			errorCount++;
			$display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
			abortRun("Stopping on the first mismatch");
		end
	endtask

	task automatic makeSlot(input int lane, input modeE mode);
		laneSlotS    s;
		int unsigned pick;
		logic [5:0]  badOp;
		s.op      = (rnd() & 1) ? ucmdAlu3 : ucmdMovIr;
		s.rn1Id   = regIdT'(rnd());
		s.rn1Val  = {rnd(), rnd()};
		s.rmId    = regIdT'(rnd());
		s.memData = {rnd(), rnd()};
		s.flush   = 1'b0;
		pick      = rnd() % 4;
		case (mode)
			modeLoad: s.op = ucmdMovMr;           // rn1Id must be ignored
			modeQuiet: begin
				if (pick == 0) s.flush = 1'b1;    // Squashed ALU op
				else if (pick == 1) s.op = ucmdNop;
				else if (pick == 2) s.op = ucmdMovRm;
				else s.rn1Id = zeroRegId;         // ALU aimed at register 63
			end
			modeConflict: begin
				if (rnd() % 4 != 0) s.rn1Id = conflictId; // Usually shared target
			end
			modeMixed: begin
				if (pick == 0) s.op = ucmdMovMr;
				else if (pick == 1) s.flush = rnd() & 1;
				else if (pick == 2) s.op = (rnd() & 1) ? ucmdNop : ucmdMovRm;
			end
			modeIllegal: begin
				badOp = rnd();
				if (badOp inside {6'h00, 6'h01, 6'h02, 6'h06, 6'h0A}) badOp ^= 6'h20;
				s.op = ucmdE'(badOp);             // Outside the legal set
			end
			default: ;
		endcase
		nextSlot[lane] = s;
	endtask

	// Lane rules applied in lane order, so the highest lane wins
	task automatic applyModel();
		for (int l = 0; l < laneCount; l++) begin
			if (!nextSlot[l].flush) begin
				case (nextSlot[l].op)
					ucmdAlu3, ucmdMovIr: if (nextSlot[l].rn1Id != zeroRegId)
						model[nextSlot[l].rn1Id] = nextSlot[l].rn1Val;
					ucmdMovMr: if (nextSlot[l].rmId != zeroRegId)
						model[nextSlot[l].rmId] = nextSlot[l].memData;
					ucmdNop, ucmdMovRm: ;
					default: expIllegal[l] = 1'b1;
				endcase
			end
		end
	endtask

	// Called on a falling edge; returns on the falling edge after the bundle is taken
	task automatic sendBundle();
		int waitCount;
		waitCount   = 0;
		bundleValid = 1'b1;
		bundleSlot  = nextSlot;
		wbStall     = (rnd() % stallOdds == 0);
		#1;
		while (!bundleReady) begin
			waitCount++;
			if (waitCount > waitLimit) abortRun("Timeout waiting for bundleReady");
			@(negedge clock);
			wbStall = (rnd() % stallOdds == 0);
			#1;
		end
		applyModel();
		@(negedge clock);
		bundleValid = 1'b0;
	endtask

	task automatic waitIdle();
		int waitCount;
		waitCount = 0;
		#1;
		while (!idle) begin
			waitCount++;
			if (waitCount > waitLimit) abortRun("Timeout waiting for the pipeline to drain");
			@(negedge clock);
			wbStall = (rnd() % stallOdds == 0);
			#1;
		end
		@(negedge clock);
		wbStall = 1'b0;
	endtask

	// Entered and left on a falling edge, one register per cycle
	task automatic sweepRegs(input string testName);
		compareValue({testName, " illegalOp"}, expIllegal, illegalOp);
		for (int r = 0; r < regCount; r++) begin
			rdId = regIdT'(r);
			#1;
			compareValue($sformatf("%s reg %0d", testName, r), model[r], rdVal);
			@(negedge clock);
		end
	endtask

	task automatic runPhase(input string testName, input modeE mode, input int count);
		int badLane;
		for (int i = 0; i < count; i++) begin
			conflictId = regIdT'(rnd() % 4);      // Small range forces overlap
			badLane    = rnd() % laneCount;
			for (int l = 0; l < laneCount; l++) begin
				makeSlot(l, (mode == modeIllegal && l != badLane) ? modeAlu : mode);
			end
			sendBundle();
			if (rnd() % 5 == 0) @(negedge clock); // Occasional bubble
		end
		waitIdle();
		sweepRegs(testName);
	endtask

	initial begin
		seed        = 32'h20f99fea;
		errorCount  = 0;
		stallOdds   = 4;
		clock       = 1'b0;
		arstN       = 1'b0;
		bundleValid = 1'b0;
		wbStall     = 1'b0;
		rdId        = '0;
		expIllegal  = '0;
		for (int l = 0; l < laneCount; l++) bundleSlot[l] = '0;
		for (int r = 0; r < regCount; r++) model[r] = '0;

		repeat (4) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		#1;
		compareValue("reset bundleReady", 1, bundleReady);
		compareValue("reset idle", 1, idle);
		@(negedge clock);
		sweepRegs("reset");

		runPhase("aluForward", modeAlu, 60);
		runPhase("loads", modeLoad, 60);
		runPhase("quietSlots", modeQuiet, 60);
		runPhase("conflicts", modeConflict, 80);
		stallOdds = 2;                            // Heavy back-pressure
		runPhase("backPressure", modeMixed, 300);
		stallOdds = 4;
		for (int k = 0; k < 6; k++) begin
			runPhase($sformatf("illegalOps%0d", k), modeIllegal, 1); // One bad lane per sweep
		end
		runPhase("illegalSticky", modeAlu, 20);

		if (errorCount == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			abortRun("Checks failed during the run");
		end
	end

endmodule

// File: execLanes.f
hw/execLanesPkg.sv
hw/laneIf.sv
hw/bundleIssue.sv
hw/ex3Lane.sv
hw/wbCollect.sv
hw/execLanes.sv
verif/execLanesTb.sv
